//--- design/dqla_pkg.sv
package dqla_pkg;

    // channel view of a register address
    typedef struct packed {
        logic [3:0] space;      // address space
        logic [3:0] chan;       // 0 = board, 1..N = motors
        logic [7:0] dev;        // device offset within channel
    } chan_addr_t;

    // block view, used for the sample buffer
    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] index;     // buffer word index
    } blk_addr_t;

    // one 16-bit address word, decoded two ways depending on space
    typedef union packed {
        chan_addr_t chan_addr;
        blk_addr_t  blk_addr;
    } reg_addr_t;

    // address spaces
    localparam logic [3:0] SPACE_CHAN   = 4'd0;
    localparam logic [3:0] SPACE_SAMPLE = 4'd1;

    // motor channel devices
    localparam logic [7:0] DEV_SETPOINT = 8'd0;
    localparam logic [7:0] DEV_FEEDBACK = 8'd1;
    localparam logic [7:0] DEV_STATUS   = 8'd2;

    // board channel (chan 0) devices
    localparam logic [7:0] BRD_STATUS      = 8'd0;
    localparam logic [7:0] BRD_WDOG_PERIOD = 8'd1;
    localparam logic [7:0] BRD_TIMESTAMP   = 8'd2;

endpackage

//--- design/rt_write_unpack.sv
`timescale 1ns/1ps

// splits a real-time block write into per-motor setpoint writes
// quadlet k -> motor k+1, quadlet NUM_MOTORS -> control word, rest dropped
module rt_write_unpack #(
    parameter int NUM_MOTORS = 8
) (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        blk_wstart,   // start of block
    input  logic        blk_wen,      // one quadlet per pulse
    input  logic [31:0] reg_wdata,
    output logic        rt_wen,       // setpoint write to rt_chan
    output logic [3:0]  rt_chan,
    output logic [31:0] rt_wdata,
    output logic        rt_ctrl_wen   // control word write
);

    // counter must reach NUM_MOTORS+1 (saturated, past control word)
    localparam int QW = $clog2(NUM_MOTORS + 2);

    logic [QW-1:0] qcnt;   // next quadlet number
    logic [QW-1:0] qidx;   // quadlet number of the current beat

    // start pulse restarts numbering, even if a beat comes with it
    assign qidx = blk_wstart ? '0 : qcnt;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            qcnt        <= '0;
            rt_wen      <= 1'b0;
            rt_ctrl_wen <= 1'b0;
        end else begin
            rt_wen      <= blk_wen && (qidx < QW'(NUM_MOTORS));   // setpoint quadlets
            rt_ctrl_wen <= blk_wen && (qidx == QW'(NUM_MOTORS));  // control quadlet
            if (blk_wen && (qidx <= QW'(NUM_MOTORS))) begin
                qcnt <= qidx + 1'b1;   // saturates at NUM_MOTORS+1
            end else if (blk_wstart) begin
                qcnt <= '0;
            end
        end
    end

    // payload, only meaningful alongside the strobes above
    always_ff @(posedge sysclk) begin
        if (blk_wen) begin
            rt_wdata <= reg_wdata;
            rt_chan  <= 4'(qidx) + 4'd1;   // motors numbered from 1
        end
    end

endmodule

//--- design/motor_chan_regs.sv
`timescale 1ns/1ps

// per-motor setpoint, amp enable and feedback registers
// fed by single host writes and by the real-time unpacker
module motor_chan_regs #(
    parameter int NUM_MOTORS = 8
) (
    input  logic                       sysclk,
    input  logic                       reset,
    input  dqla_pkg::reg_addr_t        reg_waddr,
    input  logic [31:0]                reg_wdata,
    input  logic                       reg_wen,
    input  logic                       rt_wen,
    input  logic [3:0]                 rt_chan,
    input  logic [31:0]                rt_wdata,
    input  logic                       rt_ctrl_wen,
    input  logic                       wdog_timeout,
    input  logic [NUM_MOTORS*16-1:0]   feedback,    // raw feedback inputs
    output logic [NUM_MOTORS*32-1:0]   setpoints,   // motor m at [m*32 +: 32]
    output logic [NUM_MOTORS-1:0]      amp_enable,
    output logic [NUM_MOTORS*16-1:0]   feedback_q   // registered feedback
);

    logic       wr_chan;   // single write into channel space
    logic [3:0] wr_num;    // target channel of single write
    logic       sp_wr;     // setpoint write
    logic       st_wr;     // motor status write, bit 0 = enable
    logic       rt_en_wr;  // rt control word with apply bit

    assign wr_chan  = reg_wen && (reg_waddr.chan_addr.space == dqla_pkg::SPACE_CHAN);
    assign wr_num   = reg_waddr.chan_addr.chan;
    assign sp_wr    = wr_chan && (reg_waddr.chan_addr.dev == dqla_pkg::DEV_SETPOINT);
    assign st_wr    = wr_chan && (reg_waddr.chan_addr.dev == dqla_pkg::DEV_STATUS);
    assign rt_en_wr = rt_ctrl_wen && rt_wdata[31];

    always_ff @(posedge sysclk) begin
        if (reset) begin
            setpoints  <= '0;
            amp_enable <= '0;
        end else begin
            for (int m = 0; m < NUM_MOTORS; m++) begin
                // real-time write wins on collision
                if (rt_wen && (rt_chan == 4'(m + 1))) begin
                    setpoints[m*32 +: 32] <= rt_wdata;
                end else if (sp_wr && (wr_num == 4'(m + 1))) begin
                    setpoints[m*32 +: 32] <= reg_wdata;
                end
            end

            if (wdog_timeout) begin
                amp_enable <= '0;   // amps held off until timeout cleared
            end else if (rt_en_wr) begin
                amp_enable <= rt_wdata[NUM_MOTORS-1:0];   // all motors at once
            end else begin
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    if (st_wr && (wr_num == 4'(m + 1))) begin
                        amp_enable[m] <= reg_wdata[0];
                    end
                end
            end
        end
    end

    // feedback just resampled every cycle
    always_ff @(posedge sysclk) begin
        feedback_q <= feedback;
    end

endmodule

//--- design/wdog_timer.sv
`timescale 1ns/1ps

// host watchdog, times out when no write arrives within the period
// period of 0 = disabled
module wdog_timer #(
    parameter int WDOG_WIDTH = 16
) (
    input  logic                  sysclk,
    input  logic                  reset,
    input  dqla_pkg::reg_addr_t   reg_waddr,
    input  logic [31:0]           reg_wdata,
    input  logic                  reg_wen,
    input  logic                  wdog_kick,     // any host write
    output logic [WDOG_WIDTH-1:0] wdog_period,
    output logic                  wdog_timeout
);

    logic [WDOG_WIDTH-1:0] wdog_cnt;   // idle cycles since last kick
    logic                  brd_wr;     // write to board channel
    logic                  period_wr;
    logic                  clear_wr;   // status write with bit 31

    assign brd_wr    = reg_wen && (reg_waddr.chan_addr.space == dqla_pkg::SPACE_CHAN)
                       && (reg_waddr.chan_addr.chan == 4'd0);
    assign period_wr = brd_wr && (reg_waddr.chan_addr.dev == dqla_pkg::BRD_WDOG_PERIOD);
    assign clear_wr  = brd_wr && (reg_waddr.chan_addr.dev == dqla_pkg::BRD_STATUS)
                       && reg_wdata[31];

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_period  <= '0;
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (period_wr) begin
                wdog_period <= reg_wdata[WDOG_WIDTH-1:0];
            end

            if (wdog_kick) begin
                wdog_cnt <= '0;   // restart on every host write
            end else if ((wdog_period != '0) && (wdog_cnt != wdog_period)) begin
                wdog_cnt <= wdog_cnt + 1'b1;
            end

            // sticky until host clears it, clear has priority
            if (clear_wr) begin
                wdog_timeout <= 1'b0;
            end else if (!wdog_kick && (wdog_period != '0) && (wdog_cnt == wdog_period)) begin
                wdog_timeout <= 1'b1;
            end
        end
    end

endmodule

//--- design/sample_buffer.sv
`timescale 1ns/1ps

// timestamp counter and snapshot buffer
// word 0 = timestamp at start, word k = setpoint of motor k
module sample_buffer #(
    parameter int NUM_MOTORS = 8
) (
    input  logic                     sysclk,
    input  logic                     reset,
    input  logic                     sample_start,
    input  logic [NUM_MOTORS*32-1:0] setpoints,
    input  dqla_pkg::reg_addr_t      reg_raddr,
    output logic                     sample_busy,
    output logic [31:0]              sample_rdata,
    output logic [31:0]              timestamp
);

    logic [31:0] mem [NUM_MOTORS+1];   // snapshot words
    logic [31:0] ts_latch;             // timestamp at sample start
    logic [3:0]  widx;                 // word being written
    logic [31:0] wr_word;
    logic        sample_valid;         // buffer filled at least once
    logic [11:0] rd_index;

    // free-running timestamp
    always_ff @(posedge sysclk) begin
        if (reset) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 32'd1;
        end
    end

    // one word per busy cycle, NUM_MOTORS+1 cycles in total
    always_ff @(posedge sysclk) begin
        if (reset) begin
            sample_busy  <= 1'b0;
            sample_valid <= 1'b0;
            widx         <= '0;
        end else if (sample_busy) begin
            if (widx == 4'(NUM_MOTORS)) begin
                sample_busy  <= 1'b0;   // last word written this cycle
                sample_valid <= 1'b1;
            end
            widx <= widx + 4'd1;
        end else if (sample_start) begin
            sample_busy <= 1'b1;   // start ignored while busy
            widx        <= '0;
        end
    end

    // latch time of the request, stays put during the burst
    always_ff @(posedge sysclk) begin
        if (sample_start && !sample_busy) begin
            ts_latch <= timestamp;
        end
    end

    // word 0 timestamp, otherwise setpoint of motor widx
    always_comb begin
        wr_word = ts_latch;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            if (widx == 4'(m + 1)) begin
                wr_word = setpoints[m*32 +: 32];
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (sample_busy) begin
            mem[widx] <= wr_word;
        end
    end

    // host side, outside filled range reads 0
    assign rd_index     = reg_raddr.blk_addr.index;
    assign sample_rdata = (sample_valid && (rd_index <= 12'(NUM_MOTORS)))
                          ? mem[rd_index[3:0]] : 32'd0;

endmodule

//--- design/reg_read_mux.sv
`timescale 1ns/1ps

// host read data, selected by space then channel/device, registered
module reg_read_mux #(
    parameter int NUM_MOTORS = 8,
    parameter int WDOG_WIDTH = 16
) (
    input  logic                     sysclk,
    input  logic                     reset,
    input  dqla_pkg::reg_addr_t      reg_raddr,
    input  logic [NUM_MOTORS*32-1:0] setpoints,
    input  logic [NUM_MOTORS-1:0]    amp_enable,
    input  logic [NUM_MOTORS*16-1:0] feedback_q,
    input  logic [WDOG_WIDTH-1:0]    wdog_period,
    input  logic                     wdog_timeout,
    input  logic [31:0]              timestamp,
    input  logic [31:0]              sample_rdata,
    output logic [31:0]              reg_rdata
);

    logic [31:0] rd_next;
    logic [3:0]  rd_chan;
    logic [7:0]  rd_dev;

    assign rd_chan = reg_raddr.chan_addr.chan;
    assign rd_dev  = reg_raddr.chan_addr.dev;

    always_comb begin
        rd_next = '0;   // unmapped reads 0
        case (reg_raddr.chan_addr.space)
            dqla_pkg::SPACE_CHAN: begin
                if (rd_chan == 4'd0) begin
                    // board registers
                    case (rd_dev)
                        dqla_pkg::BRD_STATUS:
                            rd_next = {wdog_timeout, {(31-NUM_MOTORS){1'b0}}, amp_enable};
                        dqla_pkg::BRD_WDOG_PERIOD:
                            rd_next = {{(32-WDOG_WIDTH){1'b0}}, wdog_period};
                        dqla_pkg::BRD_TIMESTAMP:
                            rd_next = timestamp;
                        default: rd_next = '0;
                    endcase
                end else begin
                    for (int m = 0; m < NUM_MOTORS; m++) begin
                        if (rd_chan == 4'(m + 1)) begin
                            case (rd_dev)
                                dqla_pkg::DEV_SETPOINT: rd_next = setpoints[m*32 +: 32];
                                dqla_pkg::DEV_FEEDBACK:
                                    rd_next = {16'd0, feedback_q[m*16 +: 16]};
                                dqla_pkg::DEV_STATUS:   // feedback high, enable bit 0
                                    rd_next = {feedback_q[m*16 +: 16], 15'd0, amp_enable[m]};
                                default: rd_next = '0;
                            endcase
                        end
                    end
                end
            end
            dqla_pkg::SPACE_SAMPLE: rd_next = sample_rdata;   // buffer decodes index
            default: rd_next = '0;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

//--- design/dqla_ctrl_top.sv
`timescale 1ns/1ps

// motor controller register subsystem, single sysclk domain
module dqla_ctrl_top #(
    parameter int NUM_MOTORS = 8,    // 1..15
    parameter int WDOG_WIDTH = 16    // watchdog period/counter width
) (
    input  logic                     sysclk,
    input  logic                     reset,
    input  dqla_pkg::reg_addr_t      reg_raddr,   // held by host
    input  dqla_pkg::reg_addr_t      reg_waddr,
    output logic [31:0]              reg_rdata,
    input  logic [31:0]              reg_wdata,
    input  logic                     reg_wen,
    input  logic                     blk_wen,
    input  logic                     blk_wstart,
    input  logic                     sample_start,
    input  logic [NUM_MOTORS*16-1:0] feedback,
    output logic [NUM_MOTORS-1:0]    amp_enable,
    output logic                     sample_busy,
    output logic                     wdog_timeout
);

    logic                     rt_wen;
    logic [3:0]               rt_chan;
    logic [31:0]              rt_wdata;
    logic                     rt_ctrl_wen;
    logic [NUM_MOTORS*32-1:0] setpoints;
    logic [NUM_MOTORS*16-1:0] feedback_q;
    logic [WDOG_WIDTH-1:0]    wdog_period;
    logic                     wdog_kick;     // any host write
    logic [31:0]              sample_rdata;
    logic [31:0]              timestamp;

    assign wdog_kick = reg_wen | blk_wen;

    rt_write_unpack #(.NUM_MOTORS(NUM_MOTORS)) u_rt_write_unpack (
        .sysclk(sysclk), .reset(reset),
        .blk_wstart(blk_wstart), .blk_wen(blk_wen), .reg_wdata(reg_wdata),
        .rt_wen(rt_wen), .rt_chan(rt_chan), .rt_wdata(rt_wdata), .rt_ctrl_wen(rt_ctrl_wen)
    );

    motor_chan_regs #(.NUM_MOTORS(NUM_MOTORS)) u_motor_chan_regs (
        .sysclk(sysclk), .reset(reset),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .rt_wen(rt_wen), .rt_chan(rt_chan), .rt_wdata(rt_wdata), .rt_ctrl_wen(rt_ctrl_wen),
        .wdog_timeout(wdog_timeout), .feedback(feedback),
        .setpoints(setpoints), .amp_enable(amp_enable), .feedback_q(feedback_q)
    );

    wdog_timer #(.WDOG_WIDTH(WDOG_WIDTH)) u_wdog_timer (
        .sysclk(sysclk), .reset(reset),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .wdog_kick(wdog_kick),
        .wdog_period(wdog_period), .wdog_timeout(wdog_timeout)
    );

    sample_buffer #(.NUM_MOTORS(NUM_MOTORS)) u_sample_buffer (
        .sysclk(sysclk), .reset(reset),
        .sample_start(sample_start), .setpoints(setpoints), .reg_raddr(reg_raddr),
        .sample_busy(sample_busy), .sample_rdata(sample_rdata), .timestamp(timestamp)
    );

    reg_read_mux #(.NUM_MOTORS(NUM_MOTORS), .WDOG_WIDTH(WDOG_WIDTH)) u_reg_read_mux (
        .sysclk(sysclk), .reset(reset), .reg_raddr(reg_raddr),
        .setpoints(setpoints), .amp_enable(amp_enable), .feedback_q(feedback_q),
        .wdog_period(wdog_period), .wdog_timeout(wdog_timeout),
        .timestamp(timestamp), .sample_rdata(sample_rdata),
        .reg_rdata(reg_rdata)
    );

endmodule

//--- tests/dqla_ctrl_checker.sv
`timescale 1ns/1ps

// bound into dqla_ctrl_top, watches what the host and the amps see
module dqla_ctrl_checker #(
    parameter int NUM_MOTORS = 8
) (
    input logic                  sysclk,
    input logic                  reset,
    input logic [NUM_MOTORS-1:0] amp_enable,
    input logic                  wdog_timeout,
    input logic                  sample_busy,
    input logic [31:0]           reg_rdata
);

    int busy_run;   // busy cycles before the current one

    always_ff @(posedge sysclk) begin
        if (reset) begin
            busy_run <= 0;
        end else if (sample_busy) begin
            busy_run <= busy_run + 1;
        end else begin
            busy_run <= 0;
        end
    end

    // one buffer word per busy cycle, NUM_MOTORS+1 words
    busy_length: assert property (@(posedge sysclk) disable iff (reset)
        sample_busy |-> (busy_run < NUM_MOTORS + 1))
        else $error("sample_busy high for more than %0d cycles", NUM_MOTORS + 1);

    // enables drop the cycle after timeout is seen
    amps_off: assert property (@(posedge sysclk) disable iff (reset)
        wdog_timeout |=> (amp_enable == '0))
        else $error("amp enable still high while the watchdog has timed out");

    quiet_after_reset: assert property (@(posedge sysclk)
        reset |=> (amp_enable == '0 && !wdog_timeout && !sample_busy && reg_rdata == '0))
        else $error("outputs not cleared by reset");

endmodule

//--- tests/tb_dqla_ctrl.sv
`timescale 1ns/1ps

module tb_dqla_ctrl;

    localparam int NUM_MOTORS     = 8;
    localparam int WDOG_P         = 12;     // watchdog period for the expiry test
    localparam int TIMEOUT_CYCLES = 2000;   // all tests need about 200 cycles at 8 motors

    logic                     sysclk;
    logic                     reset;
    dqla_pkg::reg_addr_t      reg_raddr;
    dqla_pkg::reg_addr_t      reg_waddr;
    logic [31:0]              reg_rdata;
    logic [31:0]              reg_wdata;
    logic                     reg_wen;
    logic                     blk_wen;
    logic                     blk_wstart;
    logic                     sample_start;
    logic [NUM_MOTORS*16-1:0] feedback;
    logic [NUM_MOTORS-1:0]    amp_enable;
    logic                     sample_busy;
    logic                     wdog_timeout;

    logic [31:0]           exp_setpoint [1:NUM_MOTORS];   // expected register contents
    logic [NUM_MOTORS-1:0] exp_enable;
    int                    error_count;
    int                    check_count;
    int                    cycle_count;
    string                 test_name;

    dqla_ctrl_top #(.NUM_MOTORS(NUM_MOTORS)) u_dqla_ctrl_top (.*);

    bind dqla_ctrl_top dqla_ctrl_checker #(.NUM_MOTORS(NUM_MOTORS)) u_dqla_ctrl_checker (
        .sysclk(sysclk), .reset(reset), .amp_enable(amp_enable),
        .wdog_timeout(wdog_timeout), .sample_busy(sample_busy), .reg_rdata(reg_rdata)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;   // 20 ns period
    end

    // run limit for a hung wait
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sysclk);
            cycle_count++;
        end
        $display("Run stopped: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    function automatic dqla_pkg::reg_addr_t chan_reg_addr(input int chan, input logic [7:0] dev);
        dqla_pkg::reg_addr_t a;
        a.chan_addr.space = dqla_pkg::SPACE_CHAN;
        a.chan_addr.chan  = 4'(chan);   // 0 = board
        a.chan_addr.dev   = dev;
        return a;
    endfunction

    function automatic dqla_pkg::reg_addr_t buffer_addr(input int index);
        dqla_pkg::reg_addr_t a;
        a.blk_addr.space = dqla_pkg::SPACE_SAMPLE;
        a.blk_addr.index = 12'(index);
        return a;
    endfunction

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s, %s: expected %08h, actual %08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_enable(input string what, input logic [NUM_MOTORS-1:0] expected,
                                input logic [NUM_MOTORS-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s, %s: expected %b, actual %b",
                     test_name, what, expected, actual);
        end
    endtask

    // all bus tasks start and end just after a falling edge
    task automatic write_reg(input dqla_pkg::reg_addr_t addr, input logic [31:0] data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);
        reg_wen   = 1'b0;
    endtask

    task automatic read_reg(input dqla_pkg::reg_addr_t addr, output logic [31:0] data);
        reg_raddr = addr;
        @(negedge sysclk);   // rdata registered one cycle later
        data = reg_rdata;
    endtask

    task automatic read_expect(input dqla_pkg::reg_addr_t addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] data;
        read_reg(addr, data);
        check_word(what, expected, data);
    endtask

    task automatic readback_setpoints();
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            read_expect(chan_reg_addr(m, dqla_pkg::DEV_SETPOINT), exp_setpoint[m],
                        $sformatf("setpoint %0d", m));
        end
    endtask

    // random setpoints, then ctrl, then one extra quadlet that must be dropped
    task automatic send_block(input logic [31:0] ctrl);
        logic [31:0] sp;
        blk_wstart = 1'b1;
        @(negedge sysclk);
        blk_wstart = 1'b0;
        blk_wen    = 1'b1;
        for (int k = 0; k < NUM_MOTORS; k++) begin
            sp = $urandom;
            exp_setpoint[k+1] = sp;   // quadlet k -> motor k+1
            reg_wdata = sp;
            @(negedge sysclk);
        end
        reg_wdata = ctrl;
        @(negedge sysclk);
        reg_wdata = $urandom;
        @(negedge sysclk);
        blk_wen = 1'b0;
        if (ctrl[31]) begin
            exp_enable = ctrl[NUM_MOTORS-1:0];
        end
        repeat (2) @(negedge sysclk);   // 2 cycles from blk_wen to register
    endtask

    task automatic reset_defaults();
        test_name = "reset_defaults";
        exp_enable = '0;
        check_enable("amp_enable", '0, amp_enable);
        check_word("wdog_timeout", 32'd0, 32'(wdog_timeout));
        check_word("sample_busy", 32'd0, 32'(sample_busy));
        read_expect(chan_reg_addr(0, dqla_pkg::BRD_STATUS), 32'd0, "board status");
        read_expect(chan_reg_addr(0, dqla_pkg::BRD_WDOG_PERIOD), 32'd0, "wdog period");
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            exp_setpoint[m] = '0;
            read_expect(chan_reg_addr(m, dqla_pkg::DEV_STATUS), 32'd0,
                        $sformatf("status %0d", m));
        end
        readback_setpoints();
        for (int i = 0; i <= NUM_MOTORS; i++) begin
            read_expect(buffer_addr(i), 32'd0, $sformatf("buffer word %0d", i));
        end
    endtask

    task automatic single_write_readback();
        logic [31:0] sp;
        logic [15:0] fb [1:NUM_MOTORS];
        test_name = "single_write_readback";
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            sp = $urandom;
            exp_setpoint[m] = sp;
            write_reg(chan_reg_addr(m, dqla_pkg::DEV_SETPOINT), sp);
        end
        readback_setpoints();
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            fb[m] = 16'($urandom);
            feedback[(m-1)*16 +: 16] = fb[m];
        end
        @(negedge sysclk);   // feedback registered in the DUT
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            read_expect(chan_reg_addr(m, dqla_pkg::DEV_STATUS), {fb[m], 15'd0, exp_enable[m-1]},
                        $sformatf("status %0d", m));
            read_expect(chan_reg_addr(m, dqla_pkg::DEV_FEEDBACK), {16'd0, fb[m]},
                        $sformatf("feedback %0d", m));
        end
        // enable the last motor through its status word
        write_reg(chan_reg_addr(NUM_MOTORS, dqla_pkg::DEV_STATUS), 32'd1);
        exp_enable[NUM_MOTORS-1] = 1'b1;
        check_enable("enable after status write", exp_enable, amp_enable);
        read_expect(chan_reg_addr(NUM_MOTORS, dqla_pkg::DEV_STATUS),
                    {fb[NUM_MOTORS], 15'd0, 1'b1}, "status after enable");
    endtask

    task automatic block_write_update();
        logic [31:0] ctrl;
        test_name = "block_write_update";
        ctrl = 32'h8000_0000;   // apply enables
        ctrl[NUM_MOTORS-1:0] = NUM_MOTORS'($urandom);
        send_block(ctrl);
        readback_setpoints();
        check_enable("enables applied", exp_enable, amp_enable);
        ctrl[31] = 1'b0;   // second burst without the apply bit
        ctrl[NUM_MOTORS-1:0] = ~ctrl[NUM_MOTORS-1:0];
        send_block(ctrl);
        readback_setpoints();
        check_enable("enables kept", exp_enable, amp_enable);
    endtask

    task automatic watchdog_expiry();
        int rise_at;
        logic [31:0] on_ctrl;
        test_name = "watchdog_expiry";
        write_reg(chan_reg_addr(0, dqla_pkg::BRD_WDOG_PERIOD), 32'(WDOG_P));
        read_expect(chan_reg_addr(0, dqla_pkg::BRD_WDOG_PERIOD), 32'(WDOG_P), "wdog period");
        on_ctrl = 32'h8000_0000;
        on_ctrl[NUM_MOTORS-1:0] = '1;   // all amps on
        send_block(on_ctrl);
        check_enable("enables before timeout", exp_enable, amp_enable);
        rise_at = 0;
        // send_block already idled 2 cycles past the last kick
        for (int i = 3; i <= WDOG_P + 3; i++) begin
            @(negedge sysclk);
            if (wdog_timeout && rise_at == 0) begin
                rise_at = i;
            end
        end
        if (rise_at == 0) begin
            error_count++;
            $display("%s: watchdog did not time out within %0d idle cycles",
                     test_name, WDOG_P + 3);
        end else begin
            check_word("idle cycles to timeout", 32'(WDOG_P + 1), 32'(rise_at));
        end
        exp_enable = '0;
        check_enable("enables after timeout", exp_enable, amp_enable);
        read_expect(chan_reg_addr(0, dqla_pkg::BRD_STATUS), 32'h8000_0000, "board status");
        write_reg(chan_reg_addr(0, dqla_pkg::BRD_STATUS), 32'h8000_0000);   // clear timeout
        check_word("wdog_timeout after clear", 32'd0, 32'(wdog_timeout));
        write_reg(chan_reg_addr(0, dqla_pkg::BRD_WDOG_PERIOD), 32'd0);   // watchdog off
        read_expect(chan_reg_addr(0, dqla_pkg::BRD_STATUS), 32'd0, "board status cleared");
    endtask

    task automatic sample_snapshot();
        logic [31:0] ts_before;
        logic [31:0] ts_after;
        logic [31:0] ts_word;
        int          busy_cycles;
        test_name = "sample_snapshot";
        read_reg(chan_reg_addr(0, dqla_pkg::BRD_TIMESTAMP), ts_before);
        sample_start = 1'b1;
        @(negedge sysclk);
        sample_start = 1'b0;
        check_word("sample_busy after start", 32'd1, 32'(sample_busy));
        busy_cycles = 0;
        while (sample_busy) begin   // bounded by the run limit
            busy_cycles++;
            sample_start = (busy_cycles == 2);   // start during busy is ignored
            @(negedge sysclk);
        end
        sample_start = 1'b0;
        check_word("busy cycles", 32'(NUM_MOTORS + 1), 32'(busy_cycles));
        read_reg(chan_reg_addr(0, dqla_pkg::BRD_TIMESTAMP), ts_after);
        read_reg(buffer_addr(0), ts_word);
        check_count++;
        if (ts_word <= ts_before || ts_word >= ts_after) begin
            error_count++;
            $display("Mismatch in %s, buffer word 0: expected between %08h and %08h, actual %08h",
                     test_name, ts_before, ts_after, ts_word);
        end
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            read_expect(buffer_addr(m), exp_setpoint[m], $sformatf("buffer word %0d", m));
        end
        read_expect(buffer_addr(NUM_MOTORS + 1), 32'd0, "buffer past end");
    endtask

    initial begin
        void'($urandom(32'h503566ba));   // seeds the generator
        error_count  = 0;
        check_count  = 0;
        reset        = 1'b1;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        blk_wstart   = 1'b0;
        sample_start = 1'b0;
        feedback     = '0;
        repeat (5) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;
        reset_defaults();
        single_write_readback();
        block_write_update();
        watchdog_expiry();
        sample_snapshot();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dqla_ctrl.f
design/dqla_pkg.sv
design/rt_write_unpack.sv
design/motor_chan_regs.sv
design/wdog_timer.sv
design/sample_buffer.sv
design/reg_read_mux.sv
design/dqla_ctrl_top.sv
tests/dqla_ctrl_checker.sv
tests/tb_dqla_ctrl.sv

//--- Makefile
TOP = tb_dqla_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f dqla_ctrl.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
